/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

	typedef logic [4:0] reg_idx_t; // architectural register number

	// base opcodes of the RV32I subset handled here
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [2:0] {
		FU_NONE   = 3'd0, // unknown opcode
		FU_UPPER  = 3'd1, // lui, auipc, jal
		FU_ALU_RR = 3'd2, // reg-reg alu
		FU_NO_WB  = 3'd3, // branch, store
		FU_ALU_RI = 3'd4  // jalr, load, op-imm
	} fu_class_e;

	// fetch delivers the instruction already split into fields
	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
	} instr_t;

	typedef struct packed {
		fu_class_e fu_class;
		reg_idx_t  rs1;
		reg_idx_t  rs2;
		reg_idx_t  rd;
		logic      reads_rs1; // cleared for x0
		logic      reads_rs2; // cleared for x0
		logic      writes_rd; // cleared for x0
	} decoded_t;

endpackage

/* src/hazard_pkg.sv */
package hazard_pkg;

	import rv_isa_pkg::*;

	typedef logic [2:0] sb_cnt_t; // cycles left to writeback

	// one scoreboard slot per architectural register
	typedef struct packed {
		logic    pending;
		sb_cnt_t countdown;
	} sb_entry_t;

	typedef struct packed {
		logic      valid;
		logic      killed;   // dropped by branch kill
		fu_class_e fu_class;
		reg_idx_t  rd;
	} issue_rep_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
	} wb_rep_t;

	typedef struct packed {
		logic    stall;
		sb_cnt_t stall_cycles; // larger of the two sources
	} stall_rep_t;

endpackage

/* src/instr_classifier.sv */
`timescale 1ns/1ps

module instr_classifier
	import rv_isa_pkg::*;
(
	input  instr_t   instr,
	output decoded_t dec
);

	fu_class_e fu_class;

	always_comb
	begin
		unique case (instr.opcode)
			LUI, AUIPC, JAL:
			begin
				fu_class = FU_UPPER;
			end
			OP:
			begin
				fu_class = FU_ALU_RR;
			end
			BRANCH, STORE:
			begin
				fu_class = FU_NO_WB;
			end
			JALR, LOAD, OP_IMM:
			begin
				fu_class = FU_ALU_RI;
			end
			default:
			begin
				fu_class = FU_NONE;
			end
		endcase
	end

	always_comb
	begin
		dec.fu_class  = fu_class;
		dec.rs1       = instr.rs1;
		dec.rs2       = instr.rs2;
		dec.rd        = instr.rd;
		// x0 reads and writes never take part in hazards
		dec.reads_rs1 = (fu_class == FU_ALU_RR || fu_class == FU_NO_WB ||
			fu_class == FU_ALU_RI) && (instr.rs1 != '0);
		dec.reads_rs2 = (fu_class == FU_ALU_RR || fu_class == FU_NO_WB) &&
			(instr.rs2 != '0);
		dec.writes_rd = (fu_class == FU_UPPER || fu_class == FU_ALU_RR ||
			fu_class == FU_ALU_RI) && (instr.rd != '0);
	end

endmodule

/* src/reg_scoreboard.sv */
`timescale 1ns/1ps

module reg_scoreboard
	import rv_isa_pkg::*;
	import hazard_pkg::*;
#(
	parameter int WB_LAT = 3
)
(
	input  logic       clk,
	input  logic       nrst,
	input  decoded_t   dec,
	input  logic       accept,
	output stall_rep_t stall_rep,
	output wb_rep_t    wb_rep
);

	localparam sb_cnt_t LAT_INIT = sb_cnt_t'(WB_LAT);

	sb_entry_t entries [32];

	sb_entry_t src1_entry;
	sb_entry_t src2_entry;
	logic      hit1;
	logic      hit2;
	sb_cnt_t   cnt1;
	sb_cnt_t   cnt2;

	// pending table with countdown to writeback
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < 32; i++)
			begin
				entries[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < 32; i++)
			begin
				if (accept && dec.writes_rd && dec.rd == reg_idx_t'(i))
				begin
					// new issue wins over a writeback to the same rd
					entries[i].pending   <= 1'b1;
					entries[i].countdown <= LAT_INIT;
				end
				else if (entries[i].pending)
				begin
					if (entries[i].countdown == sb_cnt_t'(1))
					begin
						entries[i].pending   <= 1'b0; // writeback cycle is over
						entries[i].countdown <= '0;
					end
					else
					begin
						entries[i].countdown <= entries[i].countdown - sb_cnt_t'(1);
					end
				end
			end
		end
	end

	// at most one entry reaches 1 per cycle
	always_comb
	begin
		wb_rep = '0;
		for (int i = 0; i < 32; i++)
		begin
			if (entries[i].pending && entries[i].countdown == sb_cnt_t'(1))
			begin
				wb_rep.valid = 1'b1;
				wb_rep.rd    = reg_idx_t'(i);
			end
		end
	end

	assign src1_entry = entries[dec.rs1];
	assign src2_entry = entries[dec.rs2];

	assign hit1 = dec.reads_rs1 && src1_entry.pending;
	assign hit2 = dec.reads_rs2 && src2_entry.pending;
	assign cnt1 = hit1 ? src1_entry.countdown : '0;
	assign cnt2 = hit2 ? src2_entry.countdown : '0;

	always_comb
	begin
		stall_rep.stall        = hit1 || hit2;
		stall_rep.stall_cycles = (cnt1 > cnt2) ? cnt1 : cnt2; // wait for the later one
	end

endmodule

/* src/branch_kill_ctrl.sv */
`timescale 1ns/1ps

module branch_kill_ctrl
#(
	parameter int KILL_SLOTS = 2
)
(
	input  logic clk,
	input  logic nrst,
	input  logic btaken,
	input  logic discard,
	input  logic consume,
	output logic kill_active
);

	localparam logic [1:0] SLOTS_INIT = 2'(KILL_SLOTS);

	logic [1:0] kill_cnt;

	// instructions still to drop after a taken branch
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			kill_cnt <= '0;
		end
		else if (discard)
		begin
			kill_cnt <= '0; // branch thrown away, wrong path is the right one
		end
		else if (btaken)
		begin
			kill_cnt <= SLOTS_INIT;
		end
		else if (consume && kill_active)
		begin
			kill_cnt <= kill_cnt - 2'd1;
		end
	end

	assign kill_active = (kill_cnt != '0);

endmodule

/* src/issue_front.sv */
`timescale 1ns/1ps

module issue_front
	import rv_isa_pkg::*;
	import hazard_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       req,
	input  instr_t     instr,
	output logic       ack,
	input  decoded_t   dec,
	input  logic       stall,
	input  logic       kill_active,
	output logic       accept,
	output logic       consume,
	output issue_rep_t issue_rep
);

	logic decide;

	assign decide = req && !ack; // new request, not yet answered

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			ack       <= 1'b0;
			accept    <= 1'b0;
			consume   <= 1'b0;
			issue_rep <= '0;
		end
		else
		begin
			accept          <= 1'b0;
			consume         <= 1'b0;
			issue_rep.valid <= 1'b0;

			if (ack && !req)
			begin
				ack <= 1'b0; // fetch has dropped req
			end

			if (decide && (kill_active || !stall))
			begin
				ack                <= 1'b1;
				consume            <= 1'b1;
				accept             <= !kill_active; // killed ones skip the scoreboard
				issue_rep.valid    <= 1'b1;
				issue_rep.killed   <= kill_active;
				issue_rep.fu_class <= dec.fu_class;
				issue_rep.rd       <= instr.rd; // rd field as fetched
			end
		end
	end

endmodule

/* src/hazard_unit_top.sv */
`timescale 1ns/1ps

module hazard_unit_top
	import rv_isa_pkg::*;
	import hazard_pkg::*;
#(
	parameter int WB_LAT     = 3,
	parameter int KILL_SLOTS = 2
)
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       req,
	input  instr_t     instr,
	output logic       ack,
	input  logic       btaken,
	input  logic       discard,
	output issue_rep_t issue_rep,
	output wb_rep_t    wb_rep,
	output stall_rep_t stall_rep
);

	decoded_t dec;
	logic     kill_active;
	logic     accept;
	logic     consume;

	instr_classifier u_instr_classifier (
		.instr (instr),
		.dec   (dec)
	);

	reg_scoreboard #(
		.WB_LAT (WB_LAT)
	) u_reg_scoreboard (
		.clk       (clk),
		.nrst      (nrst),
		.dec       (dec),
		.accept    (accept),
		.stall_rep (stall_rep),
		.wb_rep    (wb_rep)
	);

	branch_kill_ctrl #(
		.KILL_SLOTS (KILL_SLOTS)
	) u_branch_kill_ctrl (
		.clk         (clk),
		.nrst        (nrst),
		.btaken      (btaken),
		.discard     (discard),
		.consume     (consume),
		.kill_active (kill_active)
	);

	issue_front u_issue_front (
		.clk         (clk),
		.nrst        (nrst),
		.req         (req),
		.instr       (instr),
		.ack         (ack),
		.dec         (dec),
		.stall       (stall_rep.stall),
		.kill_active (kill_active),
		.accept      (accept),
		.consume     (consume),
		.issue_rep   (issue_rep)
	);

endmodule

/* testbench/tb_vectors.svh */
// columns: instr {opcode, rs1, rs2, rd}, btaken, discard, idle gap before the request
// a gap of 4'hf draws a random gap of 0 to 3 cycles
localparam int NUM_VEC = 21;

localparam vec_t VECTORS [NUM_VEC] = '{
	'{'{LUI,    5'd0,  5'd0,  5'd1},  1'b0, 1'b0, 4'd2},
	'{'{OP,     5'd1,  5'd2,  5'd3},  1'b0, 1'b0, 4'd0}, // waits on x1
	'{'{OP_IMM, 5'd0,  5'd3,  5'd4},  1'b0, 1'b0, 4'd0}, // rs2 not read
	'{'{STORE,  5'd4,  5'd3,  5'd0},  1'b0, 1'b0, 4'd0}, // both sources pending
	'{'{LOAD,   5'd0,  5'd0,  5'd6},  1'b0, 1'b0, 4'hf},
	'{'{JALR,   5'd0,  5'd6,  5'd7},  1'b0, 1'b0, 4'd0}, // rs2 not read
	'{'{LOAD,   5'd0,  5'd7,  5'd0},  1'b0, 1'b0, 4'd0}, // rd x0 and unread rs2
	'{'{BRANCH, 5'd7,  5'd0,  5'd5},  1'b0, 1'b0, 4'd0}, // waits on x7
	'{'{OP_IMM, 5'd0,  5'd0,  5'd8},  1'b0, 1'b0, 4'hf},
	'{'{JAL,    5'd8,  5'd8,  5'd9},  1'b0, 1'b0, 4'd0},
	'{'{AUIPC,  5'd9,  5'd9,  5'd0},  1'b0, 1'b0, 4'd0},
	'{'{opcode_e'(7'h7f), 5'd9, 5'd9, 5'd10}, 1'b0, 1'b0, 4'd0}, // unknown opcode
	'{'{OP,     5'd0,  5'd0,  5'd0},  1'b0, 1'b0, 4'd0},
	'{'{LUI,    5'd0,  5'd0,  5'd13}, 1'b0, 1'b0, 4'd0},
	'{'{OP,     5'd13, 5'd13, 5'd12}, 1'b1, 1'b0, 4'd0}, // killed though x13 pending
	'{'{OP_IMM, 5'd13, 5'd0,  5'd12}, 1'b0, 1'b0, 4'd0},
	'{'{OP_IMM, 5'd13, 5'd0,  5'd14}, 1'b0, 1'b0, 4'd0},
	'{'{LUI,    5'd0,  5'd0,  5'd15}, 1'b1, 1'b0, 4'hf},
	'{'{OP,     5'd15, 5'd0,  5'd16}, 1'b0, 1'b1, 4'd0}, // discard ends the kill
	'{'{OP,     5'd16, 5'd16, 5'd17}, 1'b1, 1'b1, 4'd0},
	'{'{STORE,  5'd17, 5'd16, 5'd0},  1'b0, 1'b0, 4'd1}
};

/* testbench/tb_hazard_unit.sv */
`timescale 1ns/1ps

module tb_hazard_unit
	import rv_isa_pkg::*;
	import hazard_pkg::*;
();

	localparam int WB_LAT     = 3;
	localparam int KILL_SLOTS = 2;
	localparam int TIMEOUT    = 20;

	typedef struct packed {
		instr_t     instr;
		logic       btaken;
		logic       discard;
		logic [3:0] gap;
	} vec_t;

	`include "tb_vectors.svh"

	logic       clk;
	logic       nrst;
	logic       req;
	instr_t     instr;
	logic       ack;
	logic       btaken;
	logic       discard;
	issue_rep_t issue_rep;
	wb_rep_t    wb_rep;
	stall_rep_t stall_rep;

	sb_entry_t  m_sb [32]; // model scoreboard
	int         m_kill;
	logic       m_ack;
	logic       m_accept;
	logic       m_consume;
	decoded_t   m_acc_dec;
	issue_rep_t m_issue;

	instr_t cur_instr;
	int     err_issue, err_wb, err_stall, err_ack, timeouts;
	int     gap;
	logic   ok;

	hazard_unit_top #(
		.WB_LAT     (WB_LAT),
		.KILL_SLOTS (KILL_SLOTS)
	) u_hazard_unit_top (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic decoded_t model_decode(instr_t i);
		decoded_t d;
		d     = '0;
		d.rs1 = i.rs1;
		d.rs2 = i.rs2;
		d.rd  = i.rd;
		case (i.opcode)
			LUI, AUIPC, JAL:    d.fu_class = FU_UPPER;
			OP:                 d.fu_class = FU_ALU_RR;
			BRANCH, STORE:      d.fu_class = FU_NO_WB;
			JALR, LOAD, OP_IMM: d.fu_class = FU_ALU_RI;
			default:            d.fu_class = FU_NONE;
		endcase
		d.reads_rs1 = (d.fu_class inside {FU_ALU_RR, FU_NO_WB, FU_ALU_RI}) && (i.rs1 != '0);
		d.reads_rs2 = (d.fu_class inside {FU_ALU_RR, FU_NO_WB}) && (i.rs2 != '0);
		d.writes_rd = (d.fu_class inside {FU_UPPER, FU_ALU_RR, FU_ALU_RI}) && (i.rd != '0);
		return d;
	endfunction

	function automatic stall_rep_t exp_stall();
		decoded_t   d;
		stall_rep_t s;
		logic       h1;
		logic       h2;
		d              = model_decode(instr);
		h1             = d.reads_rs1 && m_sb[d.rs1].pending;
		h2             = d.reads_rs2 && m_sb[d.rs2].pending;
		s.stall        = h1 || h2;
		s.stall_cycles = '0;
		if (h1)
			s.stall_cycles = m_sb[d.rs1].countdown;
		if (h2 && m_sb[d.rs2].countdown > s.stall_cycles)
			s.stall_cycles = m_sb[d.rs2].countdown;
		return s;
	endfunction

	function automatic wb_rep_t exp_wb();
		wb_rep_t w;
		w = '0;
		for (int k = 0; k < 32; k++)
		begin
			if (m_sb[k].pending && m_sb[k].countdown == 3'd1)
			begin
				w.valid = 1'b1;
				w.rd    = reg_idx_t'(k);
			end
		end
		return w;
	endfunction

	task automatic check_issue(issue_rep_t got, issue_rep_t exp);
		if (got.valid !== exp.valid || (exp.valid && got !== exp))
		begin
			err_issue++;
			$display("FAILED %0t: issue_rep got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_wb(wb_rep_t got, wb_rep_t exp);
		if (got !== exp)
		begin
			err_wb++;
			$display("FAILED %0t: wb_rep got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_stall(stall_rep_t got, stall_rep_t exp);
		if (got !== exp)
		begin
			err_stall++;
			$display("FAILED %0t: stall_rep got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_ack(logic got, logic exp);
		if (got !== exp)
		begin
			err_ack++;
			$display("FAILED %0t: ack got %b expected %b", $time, got, exp);
		end
	endtask

	task automatic tick();
		@(negedge clk);
		check_ack(ack, m_ack);
		check_issue(issue_rep, m_issue);
		check_wb(wb_rep, exp_wb());
	endtask

	// drive one cycle and step the model over the next rising edge
	task automatic apply(logic r, instr_t i, logic b, logic d);
		decoded_t   dd;
		stall_rep_t st;
		logic       kill_on;
		logic       take;
		req     = r;
		instr   = i;
		btaken  = b;
		discard = d;
		#1;
		st = exp_stall();
		check_stall(stall_rep, st);
		dd      = model_decode(i);
		kill_on = (m_kill != 0);
		take    = r && !m_ack && (kill_on || !st.stall);
		for (int k = 0; k < 32; k++)
		begin
			if (m_accept && m_acc_dec.writes_rd && m_acc_dec.rd == reg_idx_t'(k))
			begin
				m_sb[k].pending   = 1'b1;
				m_sb[k].countdown = sb_cnt_t'(WB_LAT);
			end
			else if (m_sb[k].pending)
			begin
				m_sb[k].countdown = m_sb[k].countdown - 3'd1;
				m_sb[k].pending   = (m_sb[k].countdown != '0); // free after writeback cycle
			end
		end
		if (d)
			m_kill = 0;
		else if (b)
			m_kill = KILL_SLOTS;
		else if (m_consume && kill_on)
			m_kill--;
		m_accept      = 1'b0;
		m_consume     = 1'b0;
		m_issue.valid = 1'b0;
		if (m_ack && !r)
			m_ack = 1'b0;
		if (take)
		begin
			m_ack     = 1'b1;
			m_consume = 1'b1;
			m_accept  = !kill_on;
			m_acc_dec = dd;
			m_issue   = '{1'b1, kill_on, dd.fu_class, i.rd};
		end
	endtask

	task automatic wait_ack(input logic level, output logic done);
		int n;
		n    = 0;
		done = 1'b1;
		while (ack !== level && done)
		begin
			if (n == TIMEOUT)
			begin
				$display("ack did not go to %0b within %0d cycles at %0t", level, TIMEOUT, $time);
				timeouts++;
				done = 1'b0;
			end
			else
			begin
				apply(level, cur_instr, 1'b0, 1'b0);
				tick();
				n++;
			end
		end
	endtask

	initial
	begin
		void'($urandom(32'hf3b19f9f));
		nrst      = 1'b0;
		req       = 1'b0;
		instr     = '0;
		btaken    = 1'b0;
		discard   = 1'b0;
		err_issue = 0;
		err_wb    = 0;
		err_stall = 0;
		err_ack   = 0;
		timeouts  = 0;
		m_kill    = 0;
		m_ack     = 1'b0;
		m_accept  = 1'b0;
		m_consume = 1'b0;
		m_acc_dec = '0;
		m_issue   = '0;
		cur_instr = '0;
		ok        = 1'b1;
		for (int k = 0; k < 32; k++)
			m_sb[k] = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		apply(1'b0, cur_instr, 1'b0, 1'b0);
		tick();
		for (int v = 0; v < NUM_VEC && ok; v++)
		begin
			gap = (VECTORS[v].gap == 4'hf) ? int'($urandom % 4) : int'(VECTORS[v].gap);
			repeat (gap)
			begin
				apply(1'b0, cur_instr, 1'b0, 1'b0);
				tick();
			end
			if (VECTORS[v].btaken || VECTORS[v].discard)
			begin
				apply(1'b0, cur_instr, VECTORS[v].btaken, VECTORS[v].discard);
				tick();
			end
			cur_instr = VECTORS[v].instr;
			apply(1'b1, cur_instr, 1'b0, 1'b0);
			tick();
			wait_ack(1'b1, ok);
			if (ok)
			begin
				apply(1'b0, cur_instr, 1'b0, 1'b0); // fetch drops req
				tick();
				wait_ack(1'b0, ok);
			end
		end
		repeat (2 * WB_LAT)
		begin
			apply(1'b0, cur_instr, 1'b0, 1'b0);
			tick();
		end
		$display("errors: issue %0d wb %0d stall %0d ack %0d timeouts %0d",
			err_issue, err_wb, err_stall, err_ack, timeouts);
		if (err_issue + err_wb + err_stall + err_ack + timeouts == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+testbench
src/rv_isa_pkg.sv
src/hazard_pkg.sv
src/instr_classifier.sv
src/reg_scoreboard.sv
src/branch_kill_ctrl.sv
src/issue_front.sv
src/hazard_unit_top.sv
testbench/tb_hazard_unit.sv
